/* build.f */
common/rasterPkg.sv
rtl/triangleSetup.sv
rasterizer/rasterizer.sv
rasterizer/pixelShader.sv
rtl/tileBuffer.sv
rtl/rasterTop.sv
tests/tbClock.sv
tests/rasterTb.sv

/* tests/rasterTb.sv */
`timescale 1ns/100ps

module rasterTb;

logic BOARD_CLK;
logic arstN;
rasterPkg::triangleT triangle;
logic [rasterPkg::coordW-1:0] tileX;
logic [rasterPkg::coordW-1:0] tileY;
logic rasterTileID;
logic clearTile;
logic startRasterizing;
logic doneRasterizing;
logic readTile;
logic [rasterPkg::tileIdxW-1:0] readX;
logic [rasterPkg::tileIdxW-1:0] readY;
logic [rasterPkg::colorW-1:0] readColor;

// row-major shadow tiles of the reference model
logic [rasterPkg::colorW-1:0] shadowColor [2][rasterPkg::tileDim * rasterPkg::tileDim];
logic [rasterPkg::depthW-1:0] shadowDepth [2][rasterPkg::tileDim * rasterPkg::tileDim];
logic [rasterPkg::colorW-1:0] captured [rasterPkg::tileDim * rasterPkg::tileDim];
logic [rasterPkg::colorW-1:0] saved [rasterPkg::tileDim * rasterPkg::tileDim];

integer seed = 32'h9ffbd624;
int originX = 64; // screen origin of every tile job
int originY = 96;
int passCount = 0;
int failCount = 0;

tbClock clockGen (.BOARD_CLK(BOARD_CLK), .arstN(arstN));

rasterTop rasterTop_i (.*);

function automatic rasterPkg::triangleT makeTriangle(input int x0, input int y0, input int x1,
	input int y1, input int x2, input int y2, input int depth, input int color);
	rasterPkg::triangleT t;
	t.v[0].x = x0;
	t.v[0].y = y0;
	t.v[1].x = x1;
	t.v[1].y = y1;
	t.v[2].x = x2;
	t.v[2].y = y2;
	t.depth = depth;
	t.color = color;
	return t;
endfunction

// coverage from the edge rules with orientation from the cross product
function automatic logic covers(input rasterPkg::triangleT t, input int px, input int py);
	int xs[3];
	int ys[3];
	int area;
	int ev;
	int b;
	for (int k = 0; k < 3; k++) begin
		xs[k] = t.v[k].x;
		ys[k] = t.v[k].y;
	end
	area = (xs[1] - xs[0]) * (ys[2] - ys[0]) - (xs[2] - xs[0]) * (ys[1] - ys[0]);
	if (area == 0)
		return 1'b0;
	for (int k = 0; k < 3; k++) begin
		b = (k + 1) % 3;
		ev = (ys[k] - ys[b]) * px + (xs[b] - xs[k]) * py + xs[k] * ys[b] - xs[b] * ys[k];
		if (area < 0)
			ev = -ev;
		if (ev < 0)
			return 1'b0;
	end
	return 1'b1;
endfunction

task automatic applyModel(input rasterPkg::triangleT t, input logic tid, input logic clr);
	int a;
	for (int j = 0; j < rasterPkg::tileDim; j++) begin
		for (int i = 0; i < rasterPkg::tileDim; i++) begin
			a = j * rasterPkg::tileDim + i;
			if (covers(t, originX + i, originY + j) && (clr || t.depth < shadowDepth[tid][a])) begin
				shadowColor[tid][a] = t.color;
				shadowDepth[tid][a] = t.depth;
			end
		end
	end
endtask

task automatic randomTriangle(output rasterPkg::triangleT t);
	for (int k = 0; k < 3; k++) begin
		t.v[k].x = originX - 4 + {$random(seed)} % 16; // inside or near the tile
		t.v[k].y = originY - 4 + {$random(seed)} % 16;
	end
	t.depth = 16'h0100 + {$random(seed)} % 16'hD000; // always nearer than background
	t.color = $random(seed);
endtask

// entered and left on a falling edge
task automatic runJob(input rasterPkg::triangleT t, input logic tid, input logic clr,
	input int holdCycles, inout int errs);
	int waited;
	triangle = t;
	tileX = originX;
	tileY = originY;
	rasterTileID = tid;
	clearTile = clr;
	startRasterizing = 1'b1;
	waited = 0;
	while (doneRasterizing !== 1'b1 && waited < 100) begin
		@(negedge BOARD_CLK);
		waited++;
	end
	assert (doneRasterizing === 1'b1) else begin
		$display("doneRasterizing did not rise within 100 cycles of start at %0t", $time);
		errs++;
	end
	repeat (holdCycles) begin
		@(negedge BOARD_CLK);
		assert (doneRasterizing === 1'b1) else begin
			$display("doneRasterizing dropped at %0t while start was still held", $time);
			errs++;
		end
	end
	startRasterizing = 1'b0;
	@(negedge BOARD_CLK);
	assert (doneRasterizing === 1'b0) else begin
		$display("doneRasterizing stayed high at %0t after start was released", $time);
		errs++;
	end
	applyModel(t, tid, clr);
endtask

task automatic drawBackground(input logic tid, inout int errs);
	runJob(makeTriangle(0, 0, 400, 0, 0, 400, 16'hF000, 16'h1111), tid, 1'b1, 0, errs);
endtask

task automatic checkTile(input logic tid, inout int errs);
	for (int a = 0; a < rasterPkg::tileDim * rasterPkg::tileDim; a++) begin
		readTile = tid;
		readX = a % rasterPkg::tileDim;
		readY = a / rasterPkg::tileDim;
		@(negedge BOARD_CLK); // one cycle read latency
		captured[a] = readColor;
		assert (readColor === shadowColor[tid][a]) else begin
			$display("MISMATCH time=%0t readColor tile=%0d x=%0d y=%0d expected=%h actual=%h",
				$time, tid, readX, readY, shadowColor[tid][a], readColor);
			errs++;
		end
	end
endtask

task automatic compareSaved(inout int errs);
	for (int a = 0; a < rasterPkg::tileDim * rasterPkg::tileDim; a++) begin
		assert (captured[a] === saved[a]) else begin
			$display("MISMATCH time=%0t readColor pixel=%0d expected=%h actual=%h",
				$time, a, saved[a], captured[a]);
			errs++;
		end
	end
endtask

task automatic report(input string name, input int errs);
	if (errs == 0) begin
		passCount++;
		$display("test %s passed", name);
	end else begin
		failCount++;
		$display("test %s failed with %0d errors", name, errs);
	end
endtask

initial begin : stimulus
	rasterPkg::triangleT t;
	rasterPkg::triangleT tSwap;
	int errs;
	triangle = '0;
	tileX = '0;
	tileY = '0;
	rasterTileID = 1'b0;
	clearTile = 1'b0;
	startRasterizing = 1'b0;
	readTile = 1'b0;
	readX = '0;
	readY = '0;
	@(posedge arstN);
	@(negedge BOARD_CLK);

	errs = 0;
	repeat (20) begin
		@(negedge BOARD_CLK);
		assert (doneRasterizing === 1'b0) else begin
			$display("doneRasterizing is high at %0t without any start", $time);
			errs++;
		end
	end
	report("reset", errs);

	errs = 0;
	repeat (5) begin
		drawBackground(1'b0, errs);
		randomTriangle(t);
		runJob(t, 1'b0, 1'b1, 0, errs);
		checkTile(1'b0, errs);
	end
	report("single triangles", errs);

	errs = 0;
	drawBackground(1'b0, errs);
	t = makeTriangle(58, 92, 74, 95, 63, 107, 16'h2000, 16'h5A5A);
	runJob(t, 1'b0, 1'b1, 0, errs);
	checkTile(1'b0, errs);
	foreach (saved[a])
		saved[a] = shadowColor[0][a];
	tSwap = t; // same vertices in opposite winding
	tSwap.v[1] = t.v[2];
	tSwap.v[2] = t.v[1];
	drawBackground(1'b0, errs);
	runJob(tSwap, 1'b0, 1'b1, 0, errs);
	checkTile(1'b0, errs);
	compareSaved(errs);
	runJob(makeTriangle(60, 90, 70, 100, 80, 110, 16'h0010, 16'hDEAD), 1'b0, 1'b1, 0, errs);
	checkTile(1'b0, errs);
	compareSaved(errs); // collinear points leave the tile alone
	report("orientation and degenerate", errs);

	errs = 0;
	drawBackground(1'b0, errs);
	runJob(makeTriangle(60, 92, 76, 92, 60, 108, 16'h8000, 16'hA0A0), 1'b0, 1'b0, 0, errs);
	runJob(makeTriangle(66, 94, 74, 110, 58, 104, 16'h4000, 16'hB0B0), 1'b0, 1'b0, 0, errs);
	checkTile(1'b0, errs);
	runJob(makeTriangle(56, 88, 90, 88, 56, 122, 16'hC000, 16'hC0C0), 1'b0, 1'b0, 0, errs);
	checkTile(1'b0, errs);
	report("depth test", errs);

	errs = 0;
	drawBackground(1'b1, errs);
	checkTile(1'b0, errs);
	checkTile(1'b1, errs);
	randomTriangle(t);
	runJob(t, 1'b1, 1'b1, 0, errs);
	checkTile(1'b0, errs);
	checkTile(1'b1, errs);
	randomTriangle(t);
	runJob(t, 1'b0, 1'b0, 0, errs);
	checkTile(1'b1, errs);
	checkTile(1'b0, errs);
	report("double buffering", errs);

	errs = 0;
	randomTriangle(t);
	runJob(t, 1'b0, 1'b1, 15, errs); // start held well past done
	randomTriangle(t);
	runJob(t, 1'b0, 1'b0, 0, errs);
	checkTile(1'b0, errs);
	report("level protocol", errs);

	$display("%0d tests passed, %0d tests failed", passCount, failCount);
	if (failCount == 0)
		$display("Test OK");
	else
		$display("Test FAILED");
	$finish;
end

initial begin : watchdog
	int limit;
	// 40 jobs of 200 cycles plus 20 tile readbacks
	limit = 40 * 200 + 20 * (rasterPkg::tileDim * rasterPkg::tileDim + 4);
	repeat (limit) @(posedge BOARD_CLK);
	$display("watchdog timeout, the tests did not finish within %0d cycles", limit);
	$display("Test FAILED");
	$finish;
end

endmodule

/* tests/tbClock.sv */
`timescale 1ns/100ps

module tbClock (
	output logic BOARD_CLK,
	output logic arstN
);

initial begin
	BOARD_CLK = 1'b0;
	forever #10 BOARD_CLK = ~BOARD_CLK; // 20 ns period
end

// reset held for 10 cycles, released away from the rising edge
initial begin
	arstN = 1'b0;
	repeat (10) @(posedge BOARD_CLK);
	@(negedge BOARD_CLK);
	arstN = 1'b1;
end

endmodule

/* rtl/rasterTop.sv */
`timescale 1ns/100ps

module rasterTop (
	input logic BOARD_CLK,
	input logic arstN,
	input rasterPkg::triangleT triangle,
	input logic [rasterPkg::coordW-1:0] tileX,
	input logic [rasterPkg::coordW-1:0] tileY,
	input logic rasterTileID,
	input logic clearTile,
	input logic startRasterizing,
	output logic doneRasterizing,
	input logic readTile,
	input logic [rasterPkg::tileIdxW-1:0] readX,
	input logic [rasterPkg::tileIdxW-1:0] readY,
	output logic [rasterPkg::colorW-1:0] readColor
);

logic setupLoad;
logic shaderStart;
logic shaderDone;
rasterPkg::setupT setup;
rasterPkg::jobT job;

// shader to buffer
logic [rasterPkg::tileAddrW-1:0] depthRdAddr;
logic [rasterPkg::depthW-1:0] depthRdData;
logic wrEn;
logic wrTile;
logic [rasterPkg::tileAddrW-1:0] wrAddr;
logic [rasterPkg::colorW-1:0] wrColor;
logic [rasterPkg::depthW-1:0] wrDepth;

triangleSetup triangleSetup_i (.*);

rasterizer rasterizer_i (.*);

pixelShader pixelShader_i (.*);

tileBuffer tileBuffer_i (
	.depthRdTile(job.tileId), // depth reads follow the active tile
	.*
);

endmodule

/* rtl/tileBuffer.sv */
`timescale 1ns/100ps

module tileBuffer (
	input logic BOARD_CLK,
	input logic arstN,
	input logic wrEn,
	input logic wrTile,
	input logic [rasterPkg::tileAddrW-1:0] wrAddr,
	input logic [rasterPkg::colorW-1:0] wrColor,
	input logic [rasterPkg::depthW-1:0] wrDepth,
	input logic depthRdTile,
	input logic [rasterPkg::tileAddrW-1:0] depthRdAddr,
	output logic [rasterPkg::depthW-1:0] depthRdData,
	input logic readTile,
	input logic [rasterPkg::tileIdxW-1:0] readX,
	input logic [rasterPkg::tileIdxW-1:0] readY,
	output logic [rasterPkg::colorW-1:0] readColor
);

localparam int tileWords = rasterPkg::tileDim * rasterPkg::tileDim;

// two tiles each, indexed row-major {y, x}
logic [rasterPkg::colorW-1:0] cBufferTile [2][tileWords];
logic [rasterPkg::depthW-1:0] zBufferTile [2][tileWords];

logic [rasterPkg::tileAddrW-1:0] readAddr;

assign readAddr = {readY, readX};

always_ff @(posedge BOARD_CLK) begin
	if (wrEn) begin
		cBufferTile[wrTile][wrAddr] <= wrColor;
		zBufferTile[wrTile][wrAddr] <= wrDepth;
	end
end

// registered read ports, one cycle latency
always_ff @(posedge BOARD_CLK or negedge arstN) begin
	if (!arstN) begin
		depthRdData <= '0;
		readColor <= '0;
	end else begin
		depthRdData <= zBufferTile[depthRdTile][depthRdAddr];
		readColor <= cBufferTile[readTile][readAddr]; // host readback
	end
end

endmodule

/* rasterizer/pixelShader.sv */
`timescale 1ns/100ps

module pixelShader (
	input logic BOARD_CLK,
	input logic arstN,
	input logic shaderStart,
	input rasterPkg::jobT job,
	input rasterPkg::setupT setup,
	output logic [rasterPkg::tileAddrW-1:0] depthRdAddr,
	input logic [rasterPkg::depthW-1:0] depthRdData,
	output logic wrEn,
	output logic wrTile,
	output logic [rasterPkg::tileAddrW-1:0] wrAddr,
	output logic [rasterPkg::colorW-1:0] wrColor,
	output logic [rasterPkg::depthW-1:0] wrDepth,
	output logic shaderDone
);

logic active;
logic [rasterPkg::tileIdxW-1:0] i, j; // walk position with i along x
logic lastIssue;
logic covered;
rasterPkg::pixelT p1, p2;
rasterPkg::shaderOpE op;

function automatic logic signed [rasterPkg::edgeW-1:0] evalEdge(
	input rasterPkg::edgeT e,
	input logic [rasterPkg::coordW:0] px,
	input logic [rasterPkg::coordW:0] py,
	input logic flip
);
	logic signed [rasterPkg::edgeW-1:0] a, b, c, x, y, v;
	a = $signed(e.a);
	b = $signed(e.b);
	c = $signed(e.c);
	x = px;
	y = py;
	v = a * x + b * y + c;
	return flip ? -v : v;
endfunction

assign lastIssue = (i == rasterPkg::tileDim - 1) && (j == rasterPkg::tileDim - 1);

always_ff @(posedge BOARD_CLK or negedge arstN) begin
	if (!arstN) begin
		active <= 1'b0;
		i <= '0;
		j <= '0;
	end else if (shaderStart) begin
		active <= 1'b1;
		i <= '0;
		j <= '0;
	end else if (active) begin
		i <= i + 1'b1; // wraps at tile edge
		if (i == rasterPkg::tileDim - 1)
			j <= j + 1'b1;
		if (lastIssue)
			active <= 1'b0;
	end
end

// stage 1 tests the edges at screen point (i, j)
always_comb begin : edgeStage
	logic [rasterPkg::coordW:0] px, py;
	logic inTri;
	px = job.tileX + i;
	py = job.tileY + j;
	inTri = !setup.degenerate;
	for (int k = 0; k < 3; k++) begin
		if (evalEdge(setup.e[k], px, py, setup.flipped) < 0)
			inTri = 1'b0;
	end
	covered = inTri;
end

// stage 2 reads the stored depth that arrives with p2
assign depthRdAddr = {p1.y, p1.x};

// stage 3 decision
always_comb begin
	if (!p2.valid || !p2.covered)
		op = rasterPkg::skip;
	else if (job.clearTile)
		op = rasterPkg::writeNew;
	else if (p2.depth < depthRdData)
		op = rasterPkg::writeNearer;
	else
		op = rasterPkg::skip;
end

always_ff @(posedge BOARD_CLK or negedge arstN) begin
	if (!arstN) begin
		p1 <= '0;
		p2 <= '0;
		wrEn <= 1'b0;
		shaderDone <= 1'b0;
	end else begin
		p1.valid <= active;
		p1.x <= i;
		p1.y <= j;
		p1.covered <= covered;
		p1.depth <= setup.depth;
		p1.color <= setup.color;
		p2 <= p1;
		wrEn <= (op != rasterPkg::skip);
		shaderDone <= p2.valid && (p2.x == rasterPkg::tileDim - 1)
			&& (p2.y == rasterPkg::tileDim - 1); // final pixel reaches write
	end
end

always_ff @(posedge BOARD_CLK) begin
	wrTile <= job.tileId;
	wrAddr <= {p2.y, p2.x};
	wrColor <= p2.color;
	wrDepth <= p2.depth;
end

endmodule

/* rasterizer/rasterizer.sv */
`timescale 1ns/100ps

module rasterizer (
	input logic BOARD_CLK,
	input logic arstN,
	input logic startRasterizing,
	input logic [rasterPkg::coordW-1:0] tileX,
	input logic [rasterPkg::coordW-1:0] tileY,
	input logic rasterTileID,
	input logic clearTile,
	input logic shaderDone,
	output logic setupLoad,
	output logic shaderStart,
	output rasterPkg::jobT job,
	output logic doneRasterizing
);

rasterPkg::rasterStateE state;
rasterPkg::rasterStateE nextState;

always_comb begin
	nextState = state;
	case (state)
		rasterPkg::init: begin
			if (startRasterizing)
				nextState = rasterPkg::setupWait;
		end

		rasterPkg::setupWait: begin
			nextState = rasterPkg::rasterizingBegin; // edges ready after one cycle
		end

		rasterPkg::rasterizingBegin: begin
			nextState = rasterPkg::rasterizing;
		end

		rasterPkg::rasterizing: begin
			if (shaderDone)
				nextState = rasterPkg::done;
		end

		rasterPkg::done: begin
			// hold until the host drops its request
			nextState = startRasterizing ? rasterPkg::done : rasterPkg::init;
		end

		default: nextState = rasterPkg::init;
	endcase
end

always_ff @(posedge BOARD_CLK or negedge arstN) begin
	if (!arstN) begin
		state <= rasterPkg::init;
		setupLoad <= 1'b0;
		shaderStart <= 1'b0;
		doneRasterizing <= 1'b0;
	end else begin
		state <= nextState;
		setupLoad <= (state == rasterPkg::init) && (nextState == rasterPkg::setupWait);
		shaderStart <= (state == rasterPkg::rasterizingBegin); // one-cycle kick
		doneRasterizing <= (nextState == rasterPkg::done);
	end
end

// tile parameters held for the whole pass
always_ff @(posedge BOARD_CLK) begin
	if (state == rasterPkg::rasterizingBegin) begin
		job.tileX <= tileX;
		job.tileY <= tileY;
		job.tileId <= rasterTileID;
		job.clearTile <= clearTile;
	end
end

endmodule

/* rtl/triangleSetup.sv */
`timescale 1ns/100ps

module triangleSetup (
	input logic BOARD_CLK,
	input logic arstN,
	input logic setupLoad,
	input rasterPkg::triangleT triangle,
	output rasterPkg::setupT setup
);

rasterPkg::edgeT [2:0] edgeNext;
logic signed [rasterPkg::edgeW-1:0] area; // twice the signed area

// zero-extend a screen coordinate into the constant term width
function automatic logic signed [rasterPkg::constW-1:0] widen(
	input logic [rasterPkg::coordW-1:0] v
);
	logic signed [rasterPkg::constW-1:0] r;
	r = v;
	return r;
endfunction

always_comb begin : edgeCalc
	rasterPkg::vertexT va;
	rasterPkg::vertexT vb;
	for (int k = 0; k < 3; k++) begin
		va = triangle.v[k];
		vb = triangle.v[(k == 2) ? 0 : k + 1]; // pairs 01, 12, 20
		edgeNext[k].a = {2'b00, va.y} - {2'b00, vb.y};
		edgeNext[k].b = {2'b00, vb.x} - {2'b00, va.x};
		edgeNext[k].c = widen(va.x) * widen(vb.y) - widen(vb.x) * widen(va.y);
	end
end

// shoelace sum, equals any edge evaluated at the opposite vertex
always_comb begin
	area = $signed(edgeNext[0].c) + $signed(edgeNext[1].c) + $signed(edgeNext[2].c);
end

always_ff @(posedge BOARD_CLK or negedge arstN) begin
	if (!arstN) begin
		setup <= '0;
		setup.degenerate <= 1'b1; // covers nothing until first load
	end else if (setupLoad) begin
		setup.e <= edgeNext;
		setup.flipped <= (area < 0);
		setup.degenerate <= (area == 0);
		setup.depth <= triangle.depth;
		setup.color <= triangle.color;
	end
end

endmodule

/* common/rasterPkg.sv */
package rasterPkg;

	// tile geometry
	localparam int tileDim = 8;
	localparam int tileIdxW = 3; // log2 of tileDim
	localparam int tileAddrW = 2 * tileIdxW; // row-major pixel index {y, x}

	// screen and pixel payload
	localparam int coordW = 10;
	localparam int depthW = 16;
	localparam int colorW = 16;

	// edge function arithmetic
	localparam int coefW = 12; // a and b, difference of two coordinates
	localparam int constW = 22; // c, difference of two coordinate products
	localparam int edgeW = 24; // a*x + b*y + c with margin

	typedef struct packed {
		logic [coordW-1:0] x;
		logic [coordW-1:0] y;
	} vertexT;

	// one flat-shaded triangle as supplied by the host
	typedef struct packed {
		vertexT [2:0] v;
		logic [depthW-1:0] depth;
		logic [colorW-1:0] color;
	} triangleT;

	typedef struct packed {
		logic signed [coefW-1:0] a;
		logic signed [coefW-1:0] b;
		logic signed [constW-1:0] c;
	} edgeT;

	typedef struct packed {
		edgeT [2:0] e;
		logic flipped; // signed area negative
		logic degenerate; // signed area zero
		logic [depthW-1:0] depth;
		logic [colorW-1:0] color;
	} setupT;

	// per-tile job, latched once per start
	typedef struct packed {
		logic [coordW-1:0] tileX;
		logic [coordW-1:0] tileY;
		logic tileId;
		logic clearTile;
	} jobT;

	typedef struct packed {
		logic valid;
		logic [tileIdxW-1:0] x;
		logic [tileIdxW-1:0] y;
		logic covered;
		logic [depthW-1:0] depth;
		logic [colorW-1:0] color;
	} pixelT;

	typedef enum logic [2:0] {
		init,
		setupWait,
		rasterizingBegin,
		rasterizing,
		done
	} rasterStateE;

	typedef enum logic [1:0] {
		skip,
		writeNew,
		writeNearer
	} shaderOpE;

endpackage
